/* tb.f */
hw/spio_pkg.sv
hw/spio_route_lookup.sv
hw/spio_switch.sv
hw/spio_drop_timer.sv
hw/spio_drop_stats.sv
hw/spio_router_top.sv
tests/tb_spio_router.sv

/* run.sh */
#!/bin/sh
# Build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_spio_router -f tb.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

# Pass only when the testbench printed its pass line
if ! grep -qx "TEST PASS" sim.log
then
	exit 1
fi

/* tests/tb_spio_router.sv */
/*
 * Testbench for the router with two outputs, four routes and a 16-cycle
 * drop wait. Expected routes come from a model of the table written here.
 * Random traffic keeps each ready low for at most five cycles in a row,
 * so only the timeout test expects blocked packets to be dropped.
 */
`default_nettype none

module tb_spio_router
	import spio_pkg::*;
();

	localparam int NUM_PORTS  = 2;
	localparam int NUM_ROUTES = 4;
	localparam int DROP_WAIT  = 16;
	localparam int WAIT_LIMIT = 200;

	logic                 CLK_IN;
	logic                 RESET_IN;
	logic                 rt_wr_i;
	route_idx_t           rt_idx_i;
	key_t                 rt_key_i;
	key_t                 rt_mask_i;
	logic [NUM_PORTS-1:0] rt_route_i;
	pkt_t                 in_pkt_i;
	logic                 in_vld_i;
	logic                 in_rdy_o;
	pkt_t [NUM_PORTS-1:0] out_pkt_o;
	logic [NUM_PORTS-1:0] out_vld_o;
	logic [NUM_PORTS-1:0] out_rdy_i;
	drop_rec_t            drop_rec_o;
	logic                 drop_vld_o;
	count_t               noroute_cnt_o;
	count_t               timeout_cnt_o;

	// Model of the route table as written by the testbench
	key_t                 tbl_key   [NUM_ROUTES];
	key_t                 tbl_mask  [NUM_ROUTES];
	logic [NUM_PORTS-1:0] tbl_route [NUM_ROUTES];
	// Expected traffic per output and on the drop port
	pkt_t                 exp_q0 [$];
	pkt_t                 exp_q1 [$];
	drop_rec_t            exp_drop [$];
	pkt_t                 rnd_q [$];
	count_t               exp_noroute;
	count_t               exp_timeout;
	int                   n_mismatch;
	int                   n_other;
	logic [31:0]          lcg_state;
	logic [7:0]           hdr_seq;
	logic                 stall_seen;
	logic                 rnd_done;

	spio_router_top #(
		.NUM_PORTS  (NUM_PORTS),
		.NUM_ROUTES (NUM_ROUTES),
		.DROP_WAIT  (DROP_WAIT)
	) dut (
		.CLK_IN        (CLK_IN),
		.RESET_IN      (RESET_IN),
		.rt_wr_i       (rt_wr_i),
		.rt_idx_i      (rt_idx_i),
		.rt_key_i      (rt_key_i),
		.rt_mask_i     (rt_mask_i),
		.rt_route_i    (rt_route_i),
		.in_pkt_i      (in_pkt_i),
		.in_vld_i      (in_vld_i),
		.in_rdy_o      (in_rdy_o),
		.out_pkt_o     (out_pkt_o),
		.out_vld_o     (out_vld_o),
		.out_rdy_i     (out_rdy_i),
		.drop_rec_o    (drop_rec_o),
		.drop_vld_o    (drop_vld_o),
		.noroute_cnt_o (noroute_cnt_o),
		.timeout_cnt_o (timeout_cnt_o)
	);

	always #2 CLK_IN = ~CLK_IN;

	//////////////////////////////////////////////////////////////////////
	// Reference model and compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Lowest matching index wins, no match routes nowhere
	function automatic logic [NUM_PORTS-1:0] ref_route(input key_t key);
		for (int i = 0; i < NUM_ROUTES; i++)
		begin
			if ((key & tbl_mask[i]) == tbl_key[i])
				return tbl_route[i];
		end
		return '0;
	endfunction

	// Top nibble of the key picks the route class
	function automatic pkt_t make_pkt(input logic [3:0] nib);
		pkt_t p;
		logic [31:0] r;
		r         = lcg_next();
		p.key     = {nib, r[27:0]};
		p.payload = lcg_next();
		p.hdr     = hdr_seq;
		hdr_seq   = hdr_seq + 8'd1;
		return p;
	endfunction

	task automatic check_pkt(input string name, input pkt_t got, input pkt_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got=%h exp=%h", name, got, exp);
			n_mismatch++;
		end
	endtask

	task automatic check_drop(input string name, input drop_rec_t got, input drop_rec_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got=%h exp=%h", name, got, exp);
			n_mismatch++;
		end
	endtask

	task automatic check_cnt(input string name, input count_t got, input count_t exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got=%h exp=%h", name, got, exp);
			n_mismatch++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("MISMATCH %s got=%h exp=%h", name, got, exp);
			n_mismatch++;
		end
	endtask

	task automatic abort_run(input string what);
		$display("ERROR: timed out %s", what);
		n_other++;
		$display("errors: mismatches %0d, other %0d", n_mismatch, n_other);
		$display("TEST FAIL");
		$finish;
	endtask

	// Transfers are judged mid-cycle, where valid, ready and data are settled
	always @(negedge CLK_IN)
	begin
		if (!RESET_IN)
		begin
			if (out_vld_o[0] && out_rdy_i[0])
			begin
				if (exp_q0.size() == 0)
				begin
					$display("ERROR: unexpected packet on output 0, key %h", out_pkt_o[0].key);
					n_other++;
				end
				else
					check_pkt("out_pkt_o[0]", out_pkt_o[0], exp_q0.pop_front());
			end
			if (out_vld_o[1] && out_rdy_i[1])
			begin
				if (exp_q1.size() == 0)
				begin
					$display("ERROR: unexpected packet on output 1, key %h", out_pkt_o[1].key);
					n_other++;
				end
				else
					check_pkt("out_pkt_o[1]", out_pkt_o[1], exp_q1.pop_front());
			end
			if (drop_vld_o)
			begin
				if (exp_drop.size() == 0)
				begin
					$display("ERROR: unexpected drop record, key %h", drop_rec_o.pkt.key);
					n_other++;
				end
				else
					check_drop("drop_rec_o", drop_rec_o, exp_drop.pop_front());
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks, all entered 1 unit after a rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic write_route(input int idx, input key_t key, input key_t mask,
		input logic [NUM_PORTS-1:0] route);
		rt_idx_i       = route_idx_t'(idx);
		rt_key_i       = key;
		rt_mask_i      = mask;
		rt_route_i     = route;
		rt_wr_i        = 1'b1;
		tbl_key[idx]   = key;
		tbl_mask[idx]  = mask;
		tbl_route[idx] = route;
		@(posedge CLK_IN);
		#1;
		rt_wr_i = 1'b0;
	endtask

	// Ports in skip are expected to time out, so they go to the drop record
	task automatic send_pkt(input pkt_t p, input logic [NUM_PORTS-1:0] skip);
		logic [NUM_PORTS-1:0] route;
		drop_rec_t            rec;
		int                   n;
		route = ref_route(p.key);
		if (route[0] && !skip[0])
			exp_q0.push_back(p);
		if (route[1] && !skip[1])
			exp_q1.push_back(p);
		rec.pkt     = p;
		rec.outputs = '0;
		rec.outputs[NUM_PORTS-1:0] = route & skip;
		if (route == '0 || (route & skip) != '0)
			exp_drop.push_back(rec);
		if (route == '0)
			exp_noroute++;
		else if ((route & skip) != '0)
			exp_timeout++;
		in_pkt_i = p;
		in_vld_i = 1'b1;
		for (n = 0; n < WAIT_LIMIT; n++)
		begin
			@(negedge CLK_IN);
			if (in_rdy_o)
				break;
			stall_seen = 1'b1;
		end
		if (n == WAIT_LIMIT)
			abort_run("waiting for in_rdy_o");
		@(posedge CLK_IN);
		#1;
		in_vld_i = 1'b0;
	endtask

	task automatic drain();
		int n;
		for (n = 0; n < WAIT_LIMIT; n++)
		begin
			@(posedge CLK_IN);
			if (exp_q0.size() == 0 && exp_q1.size() == 0 && exp_drop.size() == 0)
				break;
		end
		if (n == WAIT_LIMIT)
			abort_run("waiting for expected packets and drops");
		// Counters follow drop_vld by one cycle
		repeat (2) @(posedge CLK_IN);
		#1;
		check_cnt("noroute_cnt_o", noroute_cnt_o, exp_noroute);
		check_cnt("timeout_cnt_o", timeout_cnt_o, exp_timeout);
	endtask

	task automatic wait_drop();
		int n;
		for (n = 0; n < WAIT_LIMIT; n++)
		begin
			@(posedge CLK_IN);
			if (exp_drop.size() == 0)
				break;
		end
		if (n == WAIT_LIMIT)
			abort_run("waiting for the timeout drop record");
		#1;
	endtask

	// Ready runs low at most five cycles, well inside the drop wait
	task automatic drive_random_ready();
		int          n;
		int          low_run [NUM_PORTS];
		logic [31:0] r;
		for (int p = 0; p < NUM_PORTS; p++)
			low_run[p] = 0;
		for (n = 0; n < 4000 && !rnd_done; n++)
		begin
			@(posedge CLK_IN);
			#1;
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				r = lcg_next();
				if (low_run[p] >= 5 || r[31:30] != 2'b00)
				begin
					out_rdy_i[p] = 1'b1;
					low_run[p]   = 0;
				end
				else
				begin
					out_rdy_i[p] = 1'b0;
					low_run[p]++;
				end
			end
		end
		if (n == 4000)
			abort_run("random traffic never finished");
		out_rdy_i = '1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		CLK_IN      = 1'b0;
		RESET_IN    = 1'b1;
		rt_wr_i     = 1'b0;
		rt_idx_i    = '0;
		rt_key_i    = '0;
		rt_mask_i   = '0;
		rt_route_i  = '0;
		in_pkt_i    = '0;
		in_vld_i    = 1'b0;
		out_rdy_i   = '1;
		exp_noroute = '0;
		exp_timeout = '0;
		n_mismatch  = 0;
		n_other     = 0;
		lcg_state   = 32'd44;
		hdr_seq     = 8'd0;
		stall_seen  = 1'b0;
		rnd_done    = 1'b0;
		// Reset leaves every entry unable to match
		for (int i = 0; i < NUM_ROUTES; i++)
		begin
			tbl_key[i]   = '1;
			tbl_mask[i]  = '0;
			tbl_route[i] = '0;
		end
		repeat (8) @(posedge CLK_IN);
		#1;
		RESET_IN = 1'b0;
		check_bit("in_rdy_o", in_rdy_o, 1'b0);
		check_bit("out_vld_o", |out_vld_o, 1'b0);
		check_bit("drop_vld_o", drop_vld_o, 1'b0);
		check_cnt("noroute_cnt_o", noroute_cnt_o, '0);
		check_cnt("timeout_cnt_o", timeout_cnt_o, '0);
		@(posedge CLK_IN);
		#1;

		// Unicast, key 1xxxxxxx to port 0, keys 2 and 3 to port 1
		write_route(1, 32'h1000_0000, 32'hF000_0000, 2'b01);
		write_route(2, 32'h2000_0000, 32'hE000_0000, 2'b10);
		for (int i = 0; i < 8; i++)
			send_pkt(make_pkt((i % 2 == 0) ? 4'h1 : 4'h2), '0);
		drain();

		// Multicast entry 0 overrides entry 2 for key 3xxxxxxx
		write_route(0, 32'h3000_0000, 32'hF000_0000, 2'b11);
		for (int i = 0; i < 6; i++)
			send_pkt(make_pkt((i < 4) ? 4'h3 : 4'h2), '0);
		drain();

		// No-route keys
		send_pkt(make_pkt(4'h5), '0);
		send_pkt(make_pkt(4'h7), '0);
		send_pkt(make_pkt(4'hA), '0);
		send_pkt(make_pkt(4'h0), '0);
		drain();

		// Port 1 stalls for 10 cycles under multicast traffic
		stall_seen = 1'b0;
		fork
			begin
				out_rdy_i[1] = 1'b0;
				repeat (10) @(posedge CLK_IN);
				#1;
				out_rdy_i[1] = 1'b1;
			end
			begin
				for (int i = 0; i < 6; i++)
					send_pkt(make_pkt(4'h3), '0);
			end
		join
		drain();
		if (!stall_seen)
		begin
			$display("ERROR: in_rdy_o never went low while port 1 was stalled");
			n_other++;
		end

		// Port 1 stuck, the second multicast packet times out there
		out_rdy_i[1] = 1'b0;
		send_pkt(make_pkt(4'h3), '0);
		send_pkt(make_pkt(4'h3), 2'b10);
		wait_drop();
		out_rdy_i[1] = 1'b1;
		drain();
		send_pkt(make_pkt(4'h3), '0);
		drain();

		// Random keys over all route classes and random ready patterns
		for (int i = 0; i < 60; i++)
			rnd_q.push_back(make_pkt(4'((lcg_next() >> 16) % 5)));
		fork
			begin
				while (rnd_q.size() > 0)
					send_pkt(rnd_q.pop_front(), '0);
				rnd_done = 1'b1;
			end
			drive_random_ready();
		join
		drain();

		$display("errors: mismatches %0d, other %0d", n_mismatch, n_other);
		if (n_mismatch == 0 && n_other == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/spio_router_top.sv */
/*
 * Multicast router: route lookup, switch, drop timer and drop statistics.
 * Route table is written by a single-cycle strobe with no back-pressure.
 * NUM_PORTS may not exceed 8, the width of the drop record outputs field.
 */
`default_nettype none

module spio_router_top
	import spio_pkg::*;
#(
	parameter int NUM_PORTS  = 2,
	parameter int NUM_ROUTES = 4,
	parameter int DROP_WAIT  = 16
)
(
	input  wire                  CLK_IN,
	input  wire                  RESET_IN,
	// Route table writes
	input  wire                  rt_wr_i,
	input  route_idx_t           rt_idx_i,
	input  key_t                 rt_key_i,
	input  key_t                 rt_mask_i,
	input  wire  [NUM_PORTS-1:0] rt_route_i,
	// Packet in
	input  pkt_t                 in_pkt_i,
	input  wire                  in_vld_i,
	output logic                 in_rdy_o,
	// Packets out
	output pkt_t [NUM_PORTS-1:0] out_pkt_o,
	output logic [NUM_PORTS-1:0] out_vld_o,
	input  wire  [NUM_PORTS-1:0] out_rdy_i,
	// Drops and their counts
	output drop_rec_t            drop_rec_o,
	output logic                 drop_vld_o,
	output count_t               noroute_cnt_o,
	output count_t               timeout_cnt_o
);

	// Lookup to switch
	pkt_t                 sw_pkt;
	logic [NUM_PORTS-1:0] sw_sel;
	logic                 sw_vld;
	logic                 sw_rdy;
	// Switch and timer loop
	logic [NUM_PORTS-1:0] blocked;
	logic                 drop;

	spio_route_lookup #(
		.NUM_PORTS  (NUM_PORTS),
		.NUM_ROUTES (NUM_ROUTES)
	) u_lookup (
		.CLK_IN     (CLK_IN),
		.RESET_IN   (RESET_IN),
		.rt_wr_i    (rt_wr_i),
		.rt_idx_i   (rt_idx_i),
		.rt_key_i   (rt_key_i),
		.rt_mask_i  (rt_mask_i),
		.rt_route_i (rt_route_i),
		.in_pkt_i   (in_pkt_i),
		.in_vld_i   (in_vld_i),
		.in_rdy_o   (in_rdy_o),
		.out_pkt_o  (sw_pkt),
		.out_sel_o  (sw_sel),
		.out_vld_o  (sw_vld),
		.out_rdy_i  (sw_rdy)
	);

	spio_switch #(
		.NUM_PORTS (NUM_PORTS)
	) u_switch (
		.CLK_IN     (CLK_IN),
		.RESET_IN   (RESET_IN),
		.in_pkt_i   (sw_pkt),
		.in_sel_i   (sw_sel),
		.in_vld_i   (sw_vld),
		.in_rdy_o   (sw_rdy),
		.out_pkt_o  (out_pkt_o),
		.out_vld_o  (out_vld_o),
		.out_rdy_i  (out_rdy_i),
		.blocked_o  (blocked),
		.drop_i     (drop),
		.drop_rec_o (drop_rec_o),
		.drop_vld_o (drop_vld_o)
	);

	spio_drop_timer #(
		.NUM_PORTS (NUM_PORTS),
		.DROP_WAIT (DROP_WAIT)
	) u_timer (
		.CLK_IN    (CLK_IN),
		.RESET_IN  (RESET_IN),
		.blocked_i (blocked),
		.drop_o    (drop)
	);

	// Statistics see the same drop strobe as the outside
	spio_drop_stats u_stats (
		.CLK_IN        (CLK_IN),
		.RESET_IN      (RESET_IN),
		.drop_rec_i    (drop_rec_o),
		.drop_vld_i    (drop_vld_o),
		.noroute_cnt_o (noroute_cnt_o),
		.timeout_cnt_o (timeout_cnt_o)
	);

endmodule

`default_nettype wire

/* hw/spio_drop_stats.sv */
/*
 * Drop statistics. A record with no outputs counts as a no-route drop,
 * any other as a timeout drop. Both counters stick at their maximum.
 */
`default_nettype none

module spio_drop_stats
	import spio_pkg::*;
(
	input  wire       CLK_IN,
	input  wire       RESET_IN,
	input  drop_rec_t drop_rec_i,
	input  wire       drop_vld_i,
	output count_t    noroute_cnt_o,
	output count_t    timeout_cnt_o
);

	logic is_noroute;

	assign is_noroute = (drop_rec_i.outputs == '0);

	//////////////////////////////////////////////////////////////////////
	// Saturating counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			noroute_cnt_o <= '0;
			timeout_cnt_o <= '0;
		end
		else if (drop_vld_i)
		begin
			// Classify by the outputs field
			if (is_noroute && noroute_cnt_o != '1)
				noroute_cnt_o <= noroute_cnt_o + 1'b1;
			if (!is_noroute && timeout_cnt_o != '1)
				timeout_cnt_o <= timeout_cnt_o + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/spio_drop_timer.sv */
/*
 * Watchdog for blocked switch outputs. Pulses drop for one cycle after
 * DROP_WAIT consecutive blocked cycles, then counts again from zero.
 * DROP_WAIT must be at least 1.
 */
`default_nettype none

module spio_drop_timer
#(
	parameter int NUM_PORTS = 2,
	parameter int DROP_WAIT = 16
)
(
	input  wire                 CLK_IN,
	input  wire                 RESET_IN,
	input  wire [NUM_PORTS-1:0] blocked_i,
	output logic                drop_o
);

	localparam int CNT_W = $clog2(DROP_WAIT + 1);

	typedef logic [CNT_W-1:0] wait_cnt_t;

	wait_cnt_t wait_cnt;
	logic      any_blocked;

	assign any_blocked = (blocked_i != '0);

	//////////////////////////////////////////////////////////////////////
	// Wait counter
	//////////////////////////////////////////////////////////////////////

	// Pulse lands on the cycle the count reaches DROP_WAIT
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			wait_cnt <= '0;
			drop_o   <= 1'b0;
		end
		else if (!any_blocked)
		begin
			wait_cnt <= '0;
			drop_o   <= 1'b0;
		end
		else if (wait_cnt == wait_cnt_t'(DROP_WAIT - 1))
		begin
			wait_cnt <= '0;
			drop_o   <= 1'b1;
		end
		else
		begin
			wait_cnt <= wait_cnt + 1'b1;
			drop_o   <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/spio_switch.sv */
/*
 * 1-to-N multicast switch. Each selected output gets the packet as soon
 * as it is free; the input parks while any selected output is blocked.
 * A drop pulse abandons the blocked outputs of the current packet.
 * An all-zero selection drops the packet at once with outputs zero.
 */
`default_nettype none

module spio_switch
	import spio_pkg::*;
#(
	parameter int NUM_PORTS = 2
)
(
	input  wire                  CLK_IN,
	input  wire                  RESET_IN,
	// Packet in, with its selected outputs
	input  pkt_t                 in_pkt_i,
	input  wire  [NUM_PORTS-1:0] in_sel_i,
	input  wire                  in_vld_i,
	output logic                 in_rdy_o,
	// Outputs
	output pkt_t [NUM_PORTS-1:0] out_pkt_o,
	output logic [NUM_PORTS-1:0] out_vld_o,
	input  wire  [NUM_PORTS-1:0] out_rdy_i,
	// Blocked outputs and the drop request
	output logic [NUM_PORTS-1:0] blocked_o,
	input  wire                  drop_i,
	// Dropped packets, one-cycle strobe with no ready
	output drop_rec_t            drop_rec_o,
	output logic                 drop_vld_o
);

	park_state_e          state;
	pkt_t                 parked_pkt;
	logic [NUM_PORTS-1:0] parked_sel;
	// Packet being handled, parked or arriving now
	pkt_t                 cur_pkt;
	logic [NUM_PORTS-1:0] cur_sel;
	logic                 cur_vld;
	// Output holds an untaken packet and cannot load this cycle
	logic [NUM_PORTS-1:0] wait_v;
	// Outputs that already took the current packet
	logic [NUM_PORTS-1:0] accepted;
	logic [NUM_PORTS-1:0] send_now;
	logic                 sent;
	logic                 park;
	logic                 drop_now;

	assign in_rdy_o = (state == RUN);

	assign cur_pkt = (state == PARKED) ? parked_pkt : in_pkt_i;
	assign cur_sel = (state == PARKED) ? parked_sel : in_sel_i;
	assign cur_vld = (state == PARKED) ? 1'b1 : in_vld_i;

	assign wait_v    = out_vld_o & ~out_rdy_i;
	assign send_now  = {NUM_PORTS{cur_vld}} & cur_sel & ~accepted & ~wait_v;
	assign blocked_o = cur_vld ? (cur_sel & wait_v & ~accepted) : '0;

	// Done when nothing selected is still blocked, or on a drop
	assign sent = cur_vld && (blocked_o == '0 || drop_i);
	// Arriving packet finds a selected output busy
	assign park = in_rdy_o && in_vld_i && (in_sel_i & wait_v) != '0;

	assign drop_now = cur_vld && (drop_i || cur_sel == '0);

	//////////////////////////////////////////////////////////////////////
	// Parking FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			state <= RUN;
		else
		begin
			case (state)
				// A drop in the same cycle means nothing is left to park
				RUN:     if (park && !drop_i) state <= PARKED;
				PARKED:  if (sent) state <= RUN;
				default: state <= RUN;
			endcase
		end
	end

	always_ff @(posedge CLK_IN)
	begin
		if (park)
		begin
			parked_pkt <= in_pkt_i;
			parked_sel <= in_sel_i;
		end
	end

	// Cleared per packet, grows as outputs load
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			accepted <= '0;
		else if (sent)
			accepted <= '0;
		else
			accepted <= accepted | send_now;
	end

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			out_vld_o <= '0;
		else
		begin
			for (int i = 0; i < NUM_PORTS; i++)
			begin
				if (send_now[i])
					out_vld_o[i] <= 1'b1;
				else if (out_rdy_i[i])
					out_vld_o[i] <= 1'b0;
			end
		end
	end

	// Data only moves when the register is free or emptying
	always_ff @(posedge CLK_IN)
	begin
		for (int i = 0; i < NUM_PORTS; i++)
		begin
			if (send_now[i])
				out_pkt_o[i] <= cur_pkt;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Drop port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			drop_vld_o <= 1'b0;
		else
			drop_vld_o <= drop_now;
	end

	// Outputs field is zero for a no-route packet, else the blocked set
	always_ff @(posedge CLK_IN)
	begin
		if (drop_now)
		begin
			drop_rec_o.pkt                      <= cur_pkt;
			drop_rec_o.outputs                  <= '0;
			drop_rec_o.outputs[NUM_PORTS-1:0]   <= blocked_o;
		end
	end

endmodule

`default_nettype wire

/* hw/spio_route_lookup.sv */
/*
 * Key/mask route table with one registered lookup stage.
 * Lowest matching index wins; no match gives an all-zero route.
 * Table writes have no back-pressure and apply from the next lookup.
 */
`default_nettype none

module spio_route_lookup
	import spio_pkg::*;
#(
	parameter int NUM_PORTS  = 2,
	parameter int NUM_ROUTES = 4
)
(
	input  wire                  CLK_IN,
	input  wire                  RESET_IN,
	// Table write strobe
	input  wire                  rt_wr_i,
	input  route_idx_t           rt_idx_i,
	input  key_t                 rt_key_i,
	input  key_t                 rt_mask_i,
	input  wire  [NUM_PORTS-1:0] rt_route_i,
	// Packet in
	input  pkt_t                 in_pkt_i,
	input  wire                  in_vld_i,
	output logic                 in_rdy_o,
	// Packet and its route, towards the switch
	output pkt_t                 out_pkt_o,
	output logic [NUM_PORTS-1:0] out_sel_o,
	output logic                 out_vld_o,
	input  wire                  out_rdy_i
);

	key_t                 tbl_key   [NUM_ROUTES];
	key_t                 tbl_mask  [NUM_ROUTES];
	logic [NUM_PORTS-1:0] tbl_route [NUM_ROUTES];
	logic [NUM_PORTS-1:0] match_route;
	logic                 live;
	logic                 accept;

	//////////////////////////////////////////////////////////////////////
	// Route table
	//////////////////////////////////////////////////////////////////////

	// Zero mask with a nonzero key never matches, so a fresh table routes nowhere
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			for (int i = 0; i < NUM_ROUTES; i++)
			begin
				tbl_key[i]   <= '1;
				tbl_mask[i]  <= '0;
				tbl_route[i] <= '0;
			end
		end
		else if (rt_wr_i)
		begin
			for (int i = 0; i < NUM_ROUTES; i++)
			begin
				if (rt_idx_i == route_idx_t'(i))
				begin
					tbl_key[i]   <= rt_key_i;
					tbl_mask[i]  <= rt_mask_i;
					tbl_route[i] <= rt_route_i;
				end
			end
		end
	end

	// Scan from the top down so the lowest matching index is left standing
	always_comb
	begin
		match_route = '0;
		for (int i = NUM_ROUTES - 1; i >= 0; i--)
		begin
			if ((in_pkt_i.key & tbl_mask[i]) == tbl_key[i])
				match_route = tbl_route[i];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Lookup stage
	//////////////////////////////////////////////////////////////////////

	// Stage is free when empty or its packet leaves this cycle
	assign in_rdy_o = live && (!out_vld_o || out_rdy_i);
	assign accept   = in_vld_i && in_rdy_o;

	// Input opens one edge after reset
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
		begin
			live      <= 1'b0;
			out_vld_o <= 1'b0;
		end
		else
		begin
			live <= 1'b1;
			if (accept)
				out_vld_o <= 1'b1;
			else if (out_rdy_i)
				out_vld_o <= 1'b0;
		end
	end

	always_ff @(posedge CLK_IN)
	begin
		if (accept)
		begin
			out_pkt_o <= in_pkt_i;
			out_sel_o <= match_route;
		end
	end

endmodule

`default_nettype wire

/* hw/spio_pkg.sv */
/*
 * Shared types for the multicast packet router.
 * Drop records carry an outputs field sized for up to MAX_PORTS outputs;
 * designs with fewer outputs use only the low NUM_PORTS bits.
 */
`default_nettype none

package spio_pkg;

	// Upper bound on outputs that a drop record can describe
	localparam int MAX_PORTS = 8;

	// Routing key, the field matched by the route table
	typedef logic [31:0] key_t;
	typedef logic [31:0] payload_t;
	// Control byte, passed through untouched
	typedef logic [7:0]  pkt_hdr_t;

	// Unit moved on every packet port (72 bits)
	typedef struct packed {
		pkt_hdr_t hdr;
		key_t     key;
		payload_t payload;
	} pkt_t;

	// Route table entry index, up to 8 entries
	typedef logic [2:0] route_idx_t;

	// Output set at its widest, bit n is output n
	typedef logic [MAX_PORTS-1:0] port_set_t;

	// Input side of the switch
	typedef enum logic {RUN, PARKED} park_state_e;

	// One dropped packet and the outputs that never got it
	typedef struct packed {
		pkt_t      pkt;
		port_set_t outputs;
	} drop_rec_t;

	// Saturating statistics count
	typedef logic [15:0] count_t;

endpackage

`default_nettype wire
